// ==== compile.f ====
+incdir+rtl
rtl/tlk2711_rx_pkg.sv
rtl/tlk2711_rx_frame_parser.sv
rtl/tlk2711_rx_word_packer.sv
rtl/tlk2711_rx_dma_ctrl.sv
rtl/tlk2711_rx_loss_monitor.sv
rtl/tlk2711_rx_link.sv
test/tlk2711_rx_link_checker.sv
test/tlk2711_rx_link_tb.sv

// ==== rtl/tlk2711_rx_consts.svh ====
/*
 * TLK2711 receive link constants
 * code words, field widths, FIFO size and loss hold-off limit
 */
`ifndef TLK2711_RX_CONSTS_SVH
`define TLK2711_RX_CONSTS_SVH

// sync code, K28.5 low byte with D5.6 high byte
`define RX_K28_5            8'hBC
`define RX_D5_6             8'hC5

// start of frame K pair
`define RX_K27_7            8'hFB
`define RX_K28_2            8'h5C

`define RX_HEAD_FLAG        32'hEB90_E116
`define RX_LINK_LOSS_WORD   16'hFFFF

// bus and field widths
`define RX_ADDR_W           32
`define RX_DLEN_W           16
`define RX_DMA_W            64
`define RX_LINE_W           24

`define RX_FIFO_DEPTH       8

// about 100 ms at the link clock
`define RX_LOSS_HOLDOFF     24'd10_000_000
`define RX_RST_ADDR         32'h5000_0000

`endif

// ==== rtl/tlk2711_rx_dma_ctrl.sv ====
/*
 * TLK2711 receive DMA control
 * one write command per frame, address walk by the rounded byte count,
 * and the host interrupt after a set number of frames
 */
`timescale 1ns/100ps
`include "tlk2711_rx_consts.svh"

module tlk2711_rx_dma_ctrl import tlk2711_rx_pkg::*; (
    input  logic        i_2711_rx_clk,
    input  logic        i_arst_n,
    input  logic        i_rx_start,
    input  dma_addr_t   i_rx_base_addr,
    input  logic        i_hdr_done,
    input  frame_info_t i_frame_info,
    input  logic        i_frame_end,
    input  logic        i_wr_finish,
    input  line_num_t   i_rx_frames_per_intr,
    input  dlen_t       i_rx_intr_width,
    output logic        o_wr_cmd_req,
    output dma_cmd_t    o_wr_cmd,
    output logic        o_rx_interrupt
);

    dma_addr_t wr_addr;
    dlen_t     wr_bytes;
    dlen_t     round_bytes;
    line_num_t frame_cnt;
    logic      frame_done;
    logic      wr_fin;
    logic      intr_fire;
    dlen_t     intr_left;

    // DDR writes go in 8-byte units, so 882 bytes becomes 888
    assign round_bytes = {i_frame_info.data_length[`RX_DLEN_W-1:3] +
                          (`RX_DLEN_W-3)'(|i_frame_info.data_length[2:0]), 3'b000};

    always_ff @(posedge i_2711_rx_clk) begin
        if (i_hdr_done) begin
            wr_bytes <= round_bytes;
        end
    end

    always_ff @(posedge i_2711_rx_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_wr_cmd_req <= 1'b0;
            wr_addr      <= `RX_RST_ADDR;
        end else begin
            o_wr_cmd_req <= i_hdr_done;
            if (i_rx_start) begin
                wr_addr <= i_rx_base_addr;
            end else if (i_frame_end) begin
                wr_addr <= wr_addr + dma_addr_t'(wr_bytes);
            end
        end
    end

    assign o_wr_cmd = '{addr: wr_addr, bytes: wr_bytes};

    ////////////////////////////////////////////////////////////
    // host interrupt
    ////////////////////////////////////////////////////////////
    assign intr_fire = frame_done & wr_fin & (frame_cnt == i_rx_frames_per_intr);

    always_ff @(posedge i_2711_rx_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            frame_cnt  <= '0;
            frame_done <= 1'b0;
            wr_fin     <= 1'b0;
            intr_left  <= '0;
        end else begin
            // a new receive run restarts the frame accounting
            if (intr_fire || i_rx_start) begin
                frame_cnt  <= '0;
                frame_done <= 1'b0;
                wr_fin     <= 1'b0;
            end else begin
                if (i_frame_end) begin
                    frame_cnt  <= frame_cnt + line_num_t'(1);
                    frame_done <= 1'b1;
                end
                if (i_wr_finish) wr_fin <= 1'b1;
            end
            if (intr_fire) begin
                intr_left <= i_rx_intr_width;
            end else if (intr_left != '0) begin
                intr_left <= intr_left - dlen_t'(1);
            end
        end
    end

    assign o_rx_interrupt = (intr_left != '0);

endmodule

// ==== rtl/tlk2711_rx_frame_parser.sv ====
/*
 * TLK2711 receive framing
 * finds sync, start pair and head flag, captures the header words,
 * strobes out the payload and checks the 16-bit running sum
 */
`timescale 1ns/100ps
`include "tlk2711_rx_consts.svh"

module tlk2711_rx_frame_parser import tlk2711_rx_pkg::*; (
    input  logic        i_2711_rx_clk,
    input  logic        i_arst_n,
    input  rx_lane_t    i_lane,
    output logic        o_pay_valid,
    output rx_data_t    o_pay_data,
    output logic        o_frame_end,
    output logic        o_hdr_done,
    output frame_info_t o_frame_info,
    output logic        o_rx_checksum_err,
    output logic        o_in_payload,
    output rx_state_e   o_state
);

    rx_state_e   state;
    rx_state_e   state_nx;
    rx_data_t    prev_data;
    rx_data_t    sum;
    dlen_t       pay_cnt;
    dlen_t       last_word;
    logic        sync_hit;
    logic        sof_hit;

    assign sync_hit = ~i_lane.rkmsb & i_lane.rklsb &
                      (i_lane.data == {`RX_D5_6, `RX_K28_5});
    assign sof_hit  = i_lane.rkmsb & i_lane.rklsb &
                      (i_lane.data == {`RX_K28_2, `RX_K27_7});

    // index of the last payload word, ceil(length/2) - 1
    assign last_word = (o_frame_info.data_length >> 1) +
                       dlen_t'(o_frame_info.data_length[0]) - dlen_t'(1);

    ////////////////////////////////////////////////////////////
    // framing state machine
    ////////////////////////////////////////////////////////////
    always_comb begin
        state_nx = state;
        case (state)
            IDLE:        if (sync_hit) state_nx = SYNC;
            SYNC:        if (sof_hit) state_nx = FRAME_HEAD;
            FRAME_HEAD:  if ({prev_data, i_lane.data} == `RX_HEAD_FLAG) state_nx = DATA_TYPE;
            DATA_TYPE:   state_nx = LINE_INFO;
            LINE_INFO:   state_nx = DATA_LENGTH;
            DATA_LENGTH: state_nx = RECV_DATA;
            RECV_DATA:   if (pay_cnt == last_word) state_nx = CHECK_DATA;
            CHECK_DATA:  state_nx = FRAME_END1;
            FRAME_END1:  state_nx = FRAME_END2;
            default:     state_nx = IDLE;
        endcase
    end

    always_ff @(posedge i_2711_rx_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state      <= IDLE;
            pay_cnt    <= '0;
            o_hdr_done <= 1'b0;
        end else begin
            state      <= state_nx;
            o_hdr_done <= (state == DATA_LENGTH);
            if (state == RECV_DATA) begin
                pay_cnt <= pay_cnt + dlen_t'(1);
            end else begin
                pay_cnt <= '0;
            end
        end
    end

    // previous word for the 32-bit head flag
    always_ff @(posedge i_2711_rx_clk) begin
        prev_data <= i_lane.data;
    end

    // header fields, one word per state
    always_ff @(posedge i_2711_rx_clk) begin
        case (state)
            DATA_TYPE: begin
                o_frame_info.file_end    <= i_lane.data[14];
                o_frame_info.channel_id  <= i_lane.data[13:12];
                o_frame_info.data_type   <= i_lane.data[11:8];
                o_frame_info.line_number[`RX_LINE_W-1:16] <= i_lane.data[7:0];
            end
            LINE_INFO:   o_frame_info.line_number[15:0] <= i_lane.data;
            DATA_LENGTH: o_frame_info.data_length <= i_lane.data;
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // checksum from the data-type word to the last payload word
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_2711_rx_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            sum               <= '0;
            o_rx_checksum_err <= 1'b0;
        end else begin
            case (state)
                IDLE, FRAME_HEAD: sum <= '0;
                SYNC: begin
                    sum               <= '0;
                    o_rx_checksum_err <= 1'b0;
                end
                DATA_TYPE, LINE_INFO, DATA_LENGTH, RECV_DATA: begin
                    sum <= sum + i_lane.data;
                end
                CHECK_DATA: o_rx_checksum_err <= (sum != i_lane.data);
                default: ;
            endcase
        end
    end

    assign o_pay_valid  = (state == RECV_DATA);
    assign o_pay_data   = i_lane.data;
    assign o_frame_end  = (state == FRAME_END1);
    assign o_in_payload = (state >= DATA_TYPE) && (state <= CHECK_DATA);
    assign o_state      = state;

endmodule

// ==== rtl/tlk2711_rx_link.sv ====
/*
 * TLK2711 receive link top
 * lane bundling, framing, packing, DMA control and loss monitoring
 */
`timescale 1ns/100ps

module tlk2711_rx_link import tlk2711_rx_pkg::*; (
    input  logic        i_2711_rx_clk,
    input  logic        i_arst_n,
    // lane pins
    input  logic        i_2711_rkmsb,
    input  logic        i_2711_rklsb,
    input  rx_data_t    i_2711_rxd,
    // host control
    input  logic        i_rx_start,
    input  dma_addr_t   i_rx_base_addr,
    input  line_num_t   i_rx_frames_per_intr,
    input  dlen_t       i_rx_intr_width,
    input  logic        i_link_loss_ena,
    input  logic        i_sync_loss_ena,
    // DMA
    input  logic        i_dma_wr_ready,
    input  logic        i_wr_finish,
    output logic        o_wr_cmd_req,
    output dma_cmd_t    o_wr_cmd,
    output logic        o_dma_wr_valid,
    output dma_word_t   o_dma_wr_data,
    // status and interrupts
    output frame_info_t o_frame_info,
    output logic        o_rx_checksum_err,
    output logic        o_rx_interrupt,
    output logic        o_link_loss,
    output logic        o_sync_loss,
    output logic        o_loss_interrupt,
    output rx_status_t  o_rx_status
);

    rx_lane_t  lane;
    logic      pay_valid;
    rx_data_t  pay_data;
    logic      frame_end;
    logic      hdr_done;
    logic      in_payload;
    rx_state_e state;
    logic      fifo_full;
    logic      fifo_empty;

    assign lane = '{rkmsb: i_2711_rkmsb, rklsb: i_2711_rklsb, data: i_2711_rxd};

    tlk2711_rx_frame_parser u_parser (
        .i_2711_rx_clk     (i_2711_rx_clk),
        .i_arst_n          (i_arst_n),
        .i_lane            (lane),
        .o_pay_valid       (pay_valid),
        .o_pay_data        (pay_data),
        .o_frame_end       (frame_end),
        .o_hdr_done        (hdr_done),
        .o_frame_info      (o_frame_info),
        .o_rx_checksum_err (o_rx_checksum_err),
        .o_in_payload      (in_payload),
        .o_state           (state)
    );

    tlk2711_rx_word_packer u_packer (
        .i_2711_rx_clk  (i_2711_rx_clk),
        .i_arst_n       (i_arst_n),
        .i_pay_valid    (pay_valid),
        .i_pay_data     (pay_data),
        .i_frame_end    (frame_end),
        .i_dma_wr_ready (i_dma_wr_ready),
        .o_dma_wr_valid (o_dma_wr_valid),
        .o_dma_wr_data  (o_dma_wr_data),
        .o_fifo_full    (fifo_full),
        .o_fifo_empty   (fifo_empty)
    );

    tlk2711_rx_dma_ctrl u_dma_ctrl (
        .i_2711_rx_clk        (i_2711_rx_clk),
        .i_arst_n             (i_arst_n),
        .i_rx_start           (i_rx_start),
        .i_rx_base_addr       (i_rx_base_addr),
        .i_hdr_done           (hdr_done),
        .i_frame_info         (o_frame_info),
        .i_frame_end          (frame_end),
        .i_wr_finish          (i_wr_finish),
        .i_rx_frames_per_intr (i_rx_frames_per_intr),
        .i_rx_intr_width      (i_rx_intr_width),
        .o_wr_cmd_req         (o_wr_cmd_req),
        .o_wr_cmd             (o_wr_cmd),
        .o_rx_interrupt       (o_rx_interrupt)
    );

    tlk2711_rx_loss_monitor u_loss_mon (
        .i_2711_rx_clk   (i_2711_rx_clk),
        .i_arst_n        (i_arst_n),
        .i_lane          (lane),
        .i_in_payload    (in_payload),
        .i_link_loss_ena (i_link_loss_ena),
        .i_sync_loss_ena (i_sync_loss_ena),
        .o_link_loss     (o_link_loss),
        .o_sync_loss     (o_sync_loss)
    );

    assign o_loss_interrupt = o_link_loss | o_sync_loss;
    assign o_rx_status = '{state: state, fifo_full: fifo_full, fifo_empty: fifo_empty};

endmodule

// ==== rtl/tlk2711_rx_loss_monitor.sv ====
/*
 * TLK2711 link and sync loss monitor
 * one-cycle loss pulses, each detector then held off for a while
 */
`timescale 1ns/100ps
`include "tlk2711_rx_consts.svh"

module tlk2711_rx_loss_monitor import tlk2711_rx_pkg::*; (
    input  logic     i_2711_rx_clk,
    input  logic     i_arst_n,
    input  rx_lane_t i_lane,
    input  logic     i_in_payload,
    input  logic     i_link_loss_ena,
    input  logic     i_sync_loss_ena,
    output logic     o_link_loss,
    output logic     o_sync_loss
);

    // index 0 is link loss, index 1 is sync loss
    logic [1:0]  hit;
    logic [1:0]  ena;
    logic [1:0]  pulse;
    logic [1:0]  hold;
    logic [23:0] timer [2];

    // the serdes sends all-ones K words when the link drops
    assign hit[0] = i_lane.rkmsb & i_lane.rklsb & (i_lane.data == `RX_LINK_LOSS_WORD);
    // no K code may appear inside a frame
    assign hit[1] = (i_lane.rkmsb | i_lane.rklsb) & i_in_payload;
    assign ena    = {i_sync_loss_ena, i_link_loss_ena};

    always_ff @(posedge i_2711_rx_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pulse <= '0;
            hold  <= '0;
            for (int i = 0; i < 2; i++) timer[i] <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (!ena[i]) begin
                    pulse[i] <= 1'b0;
                    hold[i]  <= 1'b0;
                    timer[i] <= '0;
                end else begin
                    pulse[i] <= hit[i] & ~hold[i] & ~pulse[i];
                    if (pulse[i]) begin
                        hold[i] <= 1'b1;
                    end else if (timer[i] == `RX_LOSS_HOLDOFF) begin
                        hold[i] <= 1'b0;
                    end
                    timer[i] <= hold[i] ? timer[i] + 24'd1 : 24'd0;
                end
            end
        end
    end

    assign o_link_loss = pulse[0];
    assign o_sync_loss = pulse[1];

endmodule

// ==== rtl/tlk2711_rx_pkg.sv ====
/*
 * TLK2711 receive link types
 * lane word, DMA word and command, frame header fields, framing states
 */
`include "tlk2711_rx_consts.svh"

package tlk2711_rx_pkg;

    typedef logic [15:0]             rx_data_t;
    typedef logic [`RX_DMA_W-1:0]    dma_word_t;
    typedef logic [`RX_ADDR_W-1:0]   dma_addr_t;
    typedef logic [`RX_DLEN_W-1:0]   dlen_t;
    typedef logic [`RX_LINE_W-1:0]   line_num_t;

    // one lane word with its two K flags
    typedef struct packed {
        logic     rkmsb;
        logic     rklsb;
        rx_data_t data;
    } rx_lane_t;

    // header fields of one frame
    typedef struct packed {
        logic       file_end;
        logic [1:0] channel_id;
        logic [3:0] data_type;
        line_num_t  line_number;
        dlen_t      data_length;
    } frame_info_t;

    typedef struct packed {
        dma_addr_t addr;
        dlen_t     bytes;
    } dma_cmd_t;

    typedef enum logic [3:0] {
        IDLE,
        SYNC,
        FRAME_HEAD,
        DATA_TYPE,
        LINE_INFO,
        DATA_LENGTH,
        RECV_DATA,
        CHECK_DATA,
        FRAME_END1,
        FRAME_END2
    } rx_state_e;

    typedef struct packed {
        rx_state_e state;
        logic      fifo_full;
        logic      fifo_empty;
    } rx_status_t;

endpackage

// ==== rtl/tlk2711_rx_word_packer.sv ====
/*
 * TLK2711 receive word packer
 * packs payload words four to a DMA word, pads the tail at frame end,
 * and buffers the result in a small word FIFO read by ready
 */
`timescale 1ns/100ps
`include "tlk2711_rx_consts.svh"

module tlk2711_rx_word_packer import tlk2711_rx_pkg::*; (
    input  logic      i_2711_rx_clk,
    input  logic      i_arst_n,
    input  logic      i_pay_valid,
    input  rx_data_t  i_pay_data,
    input  logic      i_frame_end,
    input  logic      i_dma_wr_ready,
    output logic      o_dma_wr_valid,
    output dma_word_t o_dma_wr_data,
    output logic      o_fifo_full,
    output logic      o_fifo_empty
);

    localparam int AW = $clog2(`RX_FIFO_DEPTH);

    logic [1:0]    slot;
    dma_word_t     acc;
    logic          push;
    dma_word_t     push_data;
    dma_word_t     mem [`RX_FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          wr_en;

    ////////////////////////////////////////////////////////////
    // 16 to 64 bit packing, first word in the low bits
    ////////////////////////////////////////////////////////////
    always_comb begin
        push      = 1'b0;
        push_data = acc;
        if (i_pay_valid && slot == 2'd3) begin
            push      = 1'b1;
            push_data = {i_pay_data, acc[47:0]};
        end else if (i_frame_end && slot != 2'd0) begin
            // unfilled slots are still zero
            push = 1'b1;
        end
    end

    always_ff @(posedge i_2711_rx_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            slot <= 2'd0;
            acc  <= '0;
        end else if (push) begin
            slot <= 2'd0;
            acc  <= '0;
        end else if (i_pay_valid) begin
            slot             <= slot + 2'd1;
            acc[slot*16 +: 16] <= i_pay_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // word FIFO
    ////////////////////////////////////////////////////////////
    assign o_fifo_full    = (count == (AW+1)'(`RX_FIFO_DEPTH));
    assign o_fifo_empty   = (count == '0);
    // words arriving while full are lost
    assign wr_en          = push & ~o_fifo_full;
    assign o_dma_wr_valid = ~o_fifo_empty & i_dma_wr_ready;
    assign o_dma_wr_data  = mem[rd_ptr];

    always_ff @(posedge i_2711_rx_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge i_2711_rx_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (o_dma_wr_valid) rd_ptr <= rd_ptr + 1'b1;
            count <= count + (AW+1)'(wr_en) - (AW+1)'(o_dma_wr_valid);
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the receive link testbench with Verilator, then grep the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f compile.f --top-module tlk2711_rx_link_tb -o sim \
    > build.log 2>&1 && ./obj_dir/sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "ALL CHECKS PASSED" sim.log && exit 0 || exit 1

// ==== test/tlk2711_rx_link_checker.sv ====
/*
 * TLK2711 receive link protocol checks
 * command and loss pulse widths, DMA valid against ready and FIFO level
 */
`timescale 1ns/100ps

module tlk2711_rx_link_checker import tlk2711_rx_pkg::*; (
    input logic       i_2711_rx_clk,
    input logic       i_arst_n,
    input logic       o_wr_cmd_req,
    input logic       o_dma_wr_valid,
    input logic       i_dma_wr_ready,
    input rx_status_t o_rx_status,
    input logic       o_link_loss,
    input logic       o_sync_loss
);

    // number of assertion failures so far
    int fail_cnt = 0;

    a_cmd_pulse: assert property (@(posedge i_2711_rx_clk) disable iff (!i_arst_n)
        o_wr_cmd_req |=> !o_wr_cmd_req)
        else begin
            $error("write command request longer than one cycle");
            fail_cnt++;
        end

    a_valid_ready: assert property (@(posedge i_2711_rx_clk) disable iff (!i_arst_n)
        o_dma_wr_valid |-> i_dma_wr_ready)
        else begin
            $error("DMA valid while ready is low");
            fail_cnt++;
        end

    // never pop an empty FIFO
    a_valid_fifo: assert property (@(posedge i_2711_rx_clk) disable iff (!i_arst_n)
        o_dma_wr_valid |-> !o_rx_status.fifo_empty)
        else begin
            $error("DMA valid with the word FIFO empty");
            fail_cnt++;
        end

    a_link_pulse: assert property (@(posedge i_2711_rx_clk) disable iff (!i_arst_n)
        o_link_loss |=> !o_link_loss)
        else begin
            $error("link loss pulse longer than one cycle");
            fail_cnt++;
        end

    a_sync_pulse: assert property (@(posedge i_2711_rx_clk) disable iff (!i_arst_n)
        o_sync_loss |=> !o_sync_loss)
        else begin
            $error("sync loss pulse longer than one cycle");
            fail_cnt++;
        end

endmodule

bind tlk2711_rx_link tlk2711_rx_link_checker u_checker (
    .i_2711_rx_clk  (i_2711_rx_clk),
    .i_arst_n       (i_arst_n),
    .o_wr_cmd_req   (o_wr_cmd_req),
    .o_dma_wr_valid (o_dma_wr_valid),
    .i_dma_wr_ready (i_dma_wr_ready),
    .o_rx_status    (o_rx_status),
    .o_link_loss    (o_link_loss),
    .o_sync_loss    (o_sync_loss)
);

// ==== test/tlk2711_rx_link_tb.sv ====
/*
 * TLK2711 receive link testbench
 * frames from the stimulus file, DMA words, commands, checksum,
 * interrupt width and loss pulses checked against the link rules
 */
`timescale 1ns/100ps

module tlk2711_rx_link_tb import tlk2711_rx_pkg::*; ;

    logic clk, arst_n, rkmsb, rklsb, rx_start, lle, sle, ready, wr_finish;
    rx_data_t rxd;
    dma_addr_t base;
    line_num_t fpi;
    dlen_t iw;
    logic cmd_req, dma_valid, cks_err, rx_int, link_loss, sync_loss, loss_int;
    dma_cmd_t cmd;
    dma_word_t dma_data;
    frame_info_t info;
    rx_status_t status;

    integer seed = 51;
    integer errors = 0, tests = 0, failed = 0, fd, link_cnt = 0, sync_cnt = 0, lint_cnt = 0;
    integer bp_bad = 0;
    bit aborted = 0;
    dma_word_t word_q[$];
    dma_cmd_t cmd_q[$];
    integer f_test;
    dlen_t f_len, f_bytes;
    logic f_fe, f_corrupt, f_err;
    logic [1:0] f_ch;
    logic [3:0] f_dt;
    line_num_t f_line;
    rx_data_t f_start;
    dma_addr_t f_addr;
    dma_word_t f_last;

    tlk2711_rx_link dut (
        .i_2711_rx_clk(clk), .i_arst_n(arst_n), .i_2711_rkmsb(rkmsb), .i_2711_rklsb(rklsb),
        .i_2711_rxd(rxd), .i_rx_start(rx_start), .i_rx_base_addr(base),
        .i_rx_frames_per_intr(fpi), .i_rx_intr_width(iw), .i_link_loss_ena(lle),
        .i_sync_loss_ena(sle), .i_dma_wr_ready(ready), .i_wr_finish(wr_finish),
        .o_wr_cmd_req(cmd_req), .o_wr_cmd(cmd), .o_dma_wr_valid(dma_valid),
        .o_dma_wr_data(dma_data), .o_frame_info(info), .o_rx_checksum_err(cks_err),
        .o_rx_interrupt(rx_int), .o_link_loss(link_loss), .o_sync_loss(sync_loss),
        .o_loss_interrupt(loss_int), .o_rx_status(status)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // output monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (arst_n) begin
            if (dma_valid) word_q.push_back(dma_data);
            if (dma_valid && !ready) bp_bad = bp_bad + 1;
            if (cmd_req) cmd_q.push_back(cmd);
            link_cnt = link_cnt + link_loss;
            sync_cnt = sync_cnt + sync_loss;
            lint_cnt = lint_cnt + loss_int;
        end
    end

    task automatic check_word(input string name, input dma_word_t got, input dma_word_t exp);
        if (got !== exp) begin
            $display("FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_cmd(input string name, input dma_cmd_t got, input dma_cmd_t exp);
        if (got !== exp) begin
            $display("FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_info(input string name, input frame_info_t got,
                              input frame_info_t exp);
        if (got !== exp) begin
            $display("FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input bit got, input bit exp);
        if (got !== exp) begin
            $display("FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input dlen_t got, input dlen_t exp);
        if (got !== exp) begin
            $display("FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_status(input string name, input rx_status_t got,
                                input rx_status_t exp);
        if (got !== exp) begin
            $display("FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic drive_word(input logic km, input logic kl, input rx_data_t d);
        @(posedge clk);
        rkmsb <= km;
        rklsb <= kl;
        rxd   <= d;
    endtask

    task automatic idle(input int n);
        repeat (n) drive_word(1'b0, 1'b0, rx_data_t'($random(seed)));
    endtask

    task automatic read_frame();
        string line;
        int r;
        r = 0;
        while (r != 12 && !aborted) begin
            if ($fgets(line, fd) == 0) begin
                $display("stimulus file ended before all frames were read");
                errors++;
                aborted = 1;
            end else if (line.len() > 1 && line[0] != "#") begin
                r = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h", f_test, f_len,
                            f_fe, f_ch, f_dt, f_line, f_start, f_corrupt, f_err, f_addr,
                            f_bytes, f_last);
            end
        end
    endtask

    // sync, start pair, head flag, header, payload and checksum
    task automatic send_frame(input int k_at);
        rx_data_t sum;
        rx_data_t type_w;
        int i;
        type_w = {1'b0, f_fe, f_ch, f_dt, f_line[23:16]};
        sum = type_w + f_line[15:0] + f_len;
        drive_word(1'b0, 1'b1, 16'hC5BC);
        drive_word(1'b1, 1'b1, 16'h5CFB);
        drive_word(1'b0, 1'b0, 16'hEB90);
        drive_word(1'b0, 1'b0, 16'hE116);
        drive_word(1'b0, 1'b0, type_w);
        drive_word(1'b0, 1'b0, f_line[15:0]);
        drive_word(1'b0, 1'b0, f_len);
        for (i = 0; i < (f_len + 1) / 2; i++) begin
            sum = sum + rx_data_t'(f_start + i);
            drive_word(1'b0, i == k_at, rx_data_t'(f_start + i));
        end
        drive_word(1'b0, 1'b0, sum + rx_data_t'(f_corrupt));
        idle(4);
    endtask

    task automatic check_words();
        int n, j, s, t;
        dma_word_t exp;
        n = (f_len + 1) / 2;
        t = 0;
        while (word_q.size() < (n + 3) / 4 && t < 2000) begin
            @(negedge clk);
            t++;
        end
        if (word_q.size() < (n + 3) / 4) begin
            $display("timeout, only %0d of %0d DMA words arrived", word_q.size(), (n + 3) / 4);
            errors++;
            aborted = 1;
        end else begin
            for (j = 0; j < (n + 3) / 4; j++) begin
                exp = '0;
                for (s = 0; s < 4; s++)
                    if (j * 4 + s < n) exp[s*16 +: 16] = rx_data_t'(f_start + j * 4 + s);
                check_word("o_dma_wr_data", word_q[j], exp);
            end
            check_word("o_dma_wr_data last", word_q[(n + 3) / 4 - 1], f_last);
        end
    endtask

    task automatic run_frame(input int k_at, input bit with_words);
        read_frame();
        if (!aborted) begin
            word_q.delete();
            cmd_q.delete();
            send_frame(k_at);
            if (with_words) check_words();
            if (cmd_q.size() != 1) begin
                $display("expected one write command, saw %0d", cmd_q.size());
                errors++;
            end else begin
                check_cmd("o_wr_cmd", cmd_q[0], '{addr: f_addr, bytes: f_bytes});
            end
            check_info("o_frame_info", info, '{file_end: f_fe, channel_id: f_ch,
                       data_type: f_dt, line_number: f_line, data_length: f_len});
            check_flag("o_rx_checksum_err", cks_err, f_err);
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests++;
        if (errors > err_before) begin
            failed++;
            $display("test %0d %s: fail", tests, name);
        end else begin
            $display("test %0d %s: ok", tests, name);
        end
    endtask

    initial begin
        integer e, t, w, l0, s0, i0;
        {rkmsb, rklsb, rxd, rx_start, wr_finish} = '0;
        {lle, sle, ready} = 3'b111;
        base = 32'h1000_0000;
        fpi = 24'd2;
        iw = 16'd5;
        arst_n = 1'b0;
        fd = $fopen("test/tlk2711_rx_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file");
            errors++;
            aborted = 1;
        end
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        idle(3);
        rx_start <= 1'b1;
        idle(1);
        rx_start <= 1'b0;
        idle(5);

        e = errors;
        run_frame(-1, 1);
        end_test("good frame", e);

        e = errors;
        run_frame(-1, 1);
        end_test("odd length, bad checksum", e);

        e = errors;
        @(posedge clk);
        ready <= 1'b0;
        run_frame(-1, 0);
        idle(10);
        if (word_q.size() != 0) begin
            $display("DMA words were sent while ready was low");
            errors++;
        end
        // six DMA words wait in the eight-entry FIFO
        check_status("o_rx_status", status, '{state: IDLE, fifo_full: 1'b0, fifo_empty: 1'b0});
        ready <= 1'b1;
        if (!aborted) check_words();
        check_count("valid while not ready", dlen_t'(bp_bad), 16'd0);
        end_test("back-pressure", e);

        e = errors;
        @(posedge clk);
        base <= 32'h2000_0000;
        rx_start <= 1'b1;
        idle(1);
        rx_start <= 1'b0;
        run_frame(-1, 1);
        run_frame(-1, 1);
        check_flag("o_rx_interrupt", rx_int, 1'b0);
        @(posedge clk);
        wr_finish <= 1'b1;
        idle(1);
        wr_finish <= 1'b0;
        t = 0;
        while (!rx_int && t < 100 && !aborted) begin
            @(negedge clk);
            t++;
        end
        w = 0;
        while (rx_int && w < 100) begin
            @(negedge clk);
            w++;
        end
        if (t >= 100) begin
            $display("timeout, host interrupt never rose");
            errors++;
            aborted = 1;
        end
        check_count("o_rx_interrupt width", dlen_t'(w), iw);
        end_test("interrupt", e);

        e = errors;
        l0 = link_cnt;
        i0 = lint_cnt;
        drive_word(1'b1, 1'b1, 16'hFFFF);
        idle(5);
        drive_word(1'b1, 1'b1, 16'hFFFF);
        idle(5);
        check_count("o_link_loss pulses", dlen_t'(link_cnt - l0), 16'd1);
        check_count("o_loss_interrupt pulses", dlen_t'(lint_cnt - i0), 16'd1);
        end_test("link loss", e);

        e = errors;
        s0 = sync_cnt;
        run_frame(2, 1);
        check_count("o_sync_loss pulses", dlen_t'(sync_cnt - s0), 16'd1);
        end_test("sync loss", e);

        if (dut.u_checker.fail_cnt != 0) begin
            $display("%0d protocol assertions failed", dut.u_checker.fail_cnt);
            errors = errors + dut.u_checker.fail_cnt;
        end

        $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== test/tlk2711_rx_stimulus.txt ====
# test len file_end chan dtype line pay_start corrupt exp_err exp_addr exp_bytes exp_last_word
# numbers after the test id are hex, payload word k is pay_start + k
1 0010 0 1 3 000012 0100 0 0 10000000 0010 0107010601050104
2 0372 1 2 5 00abcd 1000 1 1 10000010 0378 00000000000011b8
3 0030 0 3 1 000100 2000 0 0 10000388 0030 2017201620152014
4 0010 0 0 2 000200 3000 0 0 20000000 0010 3007300630053004
4 0014 1 1 2 000201 3100 0 0 20000010 0018 0000000031093108
6 0008 0 2 7 000300 4000 0 0 20000028 0008 4003400240014000
